// ==== wb_core.f ====
+incdir+.
wb_pkg.sv
wb_gpr_if.sv
wb_ctrl.sv
gpr_slice.sv
gpr_read_mux.sv
wb_core.sv
wb_core_sva.sv
tb_wb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wb_core.f --top-module tb_wb_core -o sim_wb_core \
   && {
      out="$(./obj_dir/sim_wb_core)"
      echo "$out"
      echo "$out" | grep -q "Simulation completed successfully"
   } \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// ==== tb_wb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module tb_wb_core;

   localparam logic [1:0] K_ALU = 2'd0;
   localparam logic [1:0] K_BR  = 2'd1;
   localparam logic [1:0] K_ST  = 2'd2;
   localparam logic [1:0] K_HLT = 2'd3;

   typedef struct packed {
      logic [31:0] word;
      logic [31:0] res_a;
      logic [31:0] res_b;
      logic [31:0] res_c;
      logic [31:0] flg;
      logic [31:0] neip;
      logic [31:0] target;
      logic [31:0] addr;
   } row_t;

   logic        clk;
   logic        arst_n;
   logic        in_valid;
   logic [31:0] in_ctrl;
   logic [31:0] in_result_a;
   logic [31:0] in_result_b;
   logic [31:0] in_result_c;
   logic [31:0] in_flags;
   logic [31:0] in_neip;
   logic [31:0] in_target;
   logic [31:0] in_addr;
   logic        stall;
   logic        store_valid;
   logic [31:0] store_addr;
   logic [31:0] store_data;
   logic        credit_return;
   logic [2:0]  rd_addr_a;
   logic [2:0]  rd_addr_b;
   logic [31:0] rd_data_a;
   logic [31:0] rd_data_b;
   logic [31:0] eip;
   logic [31:0] flags;
   logic        halted;
   logic        branch_taken;

   row_t        rows[$];
   int          errors;
   int          cycle;
   int          due[$];
   logic [31:0] exp_st_addr[$];
   logic [31:0] exp_st_data[$];
   logic [31:0] got_st_addr[$];
   logic [31:0] got_st_data[$];
   logic        saw_stall;
   logic [31:0] lcg_state;

   // reference state
   logic [31:0] m_regs[`WB_NUM_GPR];
   logic [31:0] m_flags;
   logic [31:0] m_eip;
   logic        m_halted;
   int          m_credits;

   wb_core i_dut (
      .clk           (clk),
      .arst_n        (arst_n),
      .in_valid      (in_valid),
      .in_ctrl       (in_ctrl),
      .in_result_a   (in_result_a),
      .in_result_b   (in_result_b),
      .in_result_c   (in_result_c),
      .in_flags      (in_flags),
      .in_neip       (in_neip),
      .in_target     (in_target),
      .in_addr       (in_addr),
      .stall         (stall),
      .store_valid   (store_valid),
      .store_addr    (store_addr),
      .store_data    (store_data),
      .credit_return (credit_return),
      .rd_addr_a     (rd_addr_a),
      .rd_addr_b     (rd_addr_b),
      .rd_data_a     (rd_data_a),
      .rd_data_b     (rd_data_b),
      .eip           (eip),
      .flags         (flags),
      .halted        (halted),
      .branch_taken  (branch_taken)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // ld is {ld_gpr1, ld_gpr2, ld_gpr3}
   function automatic logic [31:0] alu_word(input logic [1:0] kind, input logic [2:0] ld,
                                            input logic [2:0] d1, input logic [2:0] d2,
                                            input logic [2:0] d3, input logic [1:0] sz,
                                            input logic ldf, input logic [7:0] mask);
      return {kind, ld, d1, d2, d3, sz, ldf, mask, 7'd0};
   endfunction

   function automatic logic [31:0] br_word(input logic [1:0] cond);
      return {K_BR, cond, 28'd0};
   endfunction

   function automatic logic [31:0] merge_size(input logic [31:0] old_v,
                                              input logic [31:0] new_v,
                                              input logic [1:0] sz);
      if (sz == 2'd0) return {old_v[31:8], new_v[7:0]};
      if (sz == 2'd1) return {old_v[31:16], new_v[15:0]};
      return new_v;
   endfunction

   function automatic logic cond_met(input logic [1:0] cond, input logic [31:0] f);
      case (cond)
         2'd0:    return 1'b1;
         2'd1:    return !f[6];
         2'd2:    return !f[0] && !f[6];
         default: return f[0];
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic add_row(input logic [31:0] word, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] c,
                          input logic [31:0] fl);
      row_t r;
      int   n;
      n        = rows.size();
      r.word   = word;
      r.res_a  = a;
      r.res_b  = b;
      r.res_c  = c;
      r.flg    = fl;
      r.neip   = 32'h100 + 32'(n * 4);
      r.target = 32'h8000 + 32'(n * 16);
      r.addr   = 32'h1000 + 32'(n * 4);
      rows.push_back(r);
   endtask

   task automatic model_retire(input row_t r);
      logic [1:0]  kind;
      logic [2:0]  dr[3];
      logic [7:0]  mask;
      logic        hit;
      logic [31:0] sel;
      kind  = r.word[31:30];
      dr[0] = r.word[26:24];
      dr[1] = r.word[23:21];
      dr[2] = r.word[20:18];
      mask  = r.word[14:7];
      if (kind == K_ALU || kind == K_ST) begin
         for (int g = 0; g < `WB_NUM_GPR; g++) begin
            hit = 1'b0;
            sel = '0;
            // port 3 over port 2 over port 1
            if (r.word[29] && dr[0] == 3'(g)) begin
               hit = 1'b1;
               sel = r.res_a;
            end
            if (r.word[28] && dr[1] == 3'(g)) begin
               hit = 1'b1;
               sel = r.res_b;
            end
            if (r.word[27] && dr[2] == 3'(g)) begin
               hit = 1'b1;
               sel = r.res_c;
            end
            if (hit) m_regs[g] = merge_size(m_regs[g], sel, r.word[17:16]);
         end
         if (r.word[15]) m_flags = (m_flags & ~{24'd0, mask}) | (r.flg & {24'd0, mask});
      end
      if (kind == K_BR && cond_met(r.word[29:28], m_flags)) m_eip = r.target;
      else m_eip = r.neip;
      if (kind == K_HLT) m_halted = 1'b1;
      if (kind == K_ST) m_credits--;
   endtask

   task automatic check_state();
      for (int g = 0; g < `WB_NUM_GPR; g++) begin
         rd_addr_a = 3'(g);
         rd_addr_b = 3'(`WB_NUM_GPR - 1 - g);
         #1;
         check_value("rd_data_a", rd_data_a, m_regs[g]);
         check_value("rd_data_b", rd_data_b, m_regs[`WB_NUM_GPR - 1 - g]);
      end
      check_value("eip", eip, m_eip);
      check_value("flags", flags, m_flags);
      check_value("halted", 32'(halted), 32'(m_halted));
   endtask

   task automatic run_row(input row_t r);
      logic [1:0] kind;
      logic       exp_taken;
      kind = r.word[31:30];
      @(negedge clk);
      in_ctrl     = r.word;
      in_result_a = r.res_a;
      in_result_b = r.res_b;
      in_result_c = r.res_c;
      in_flags    = r.flg;
      in_neip     = r.neip;
      in_target   = r.target;
      in_addr     = r.addr;
      in_valid    = 1'b1;
      #1;
      if (m_halted) begin
         check_value("stall", 32'(stall), 32'd0);
         check_value("store_valid", 32'(store_valid), 32'd0);
         check_value("branch_taken", 32'(branch_taken), 32'd0);
         @(negedge clk);
         in_valid = 1'b0;
         check_state();
         return;
      end
      check_value("stall", 32'(stall), 32'((kind == K_ST) && (m_credits == 0)));
      // producer holds the uop while stalled
      while (stall) begin
         saw_stall = 1'b1;
         @(negedge clk);
         #1;
      end
      exp_taken = (kind == K_BR) && cond_met(r.word[29:28], m_flags);
      check_value("branch_taken", 32'(branch_taken), 32'(exp_taken));
      check_value("store_valid", 32'(store_valid), 32'(kind == K_ST));
      if (kind == K_ST) begin
         exp_st_addr.push_back(r.addr);
         exp_st_data.push_back(r.res_c);
      end
      @(posedge clk);
      model_retire(r);
      @(negedge clk);
      in_valid = 1'b0;
      check_state();
   endtask

   // dcache model returning one credit per store after a random delay
   initial begin
      credit_return = 1'b0;
      cycle         = 0;
      forever begin
         @(posedge clk);
         if (arst_n && credit_return) m_credits++;
         if (arst_n && store_valid) begin
            got_st_addr.push_back(store_addr);
            got_st_data.push_back(store_data);
            due.push_back(cycle + 2 + int'((lcg_next() >> 16) & 32'h7));
         end
         @(negedge clk);
         cycle++;
         credit_return = 1'b0;
         if (due.size() > 0 && due[0] <= cycle) begin
            void'(due.pop_front());
            credit_return = 1'b1;
         end
      end
   end

   initial begin
      #1;
      repeat (16 + rows.size() * 40 + 200) @(posedge clk);
      $display("[ERROR] watchdog expired before the test sequence finished");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      arst_n      = 1'b0;
      in_valid    = 1'b0;
      in_ctrl     = '0;
      in_result_a = '0;
      in_result_b = '0;
      in_result_c = '0;
      in_flags    = '0;
      in_neip     = '0;
      in_target   = '0;
      in_addr     = '0;
      rd_addr_a   = '0;
      rd_addr_b   = '0;
      errors      = 0;
      saw_stall   = 1'b0;
      lcg_state   = 32'd15;
      m_flags     = '0;
      m_eip       = '0;
      m_halted    = 1'b0;
      m_credits   = `WB_STORE_CREDITS;
      for (int g = 0; g < `WB_NUM_GPR; g++) m_regs[g] = '0;

      // register writes, sizes and port priority
      add_row(alu_word(K_ALU, 3'b111, 3'd1, 3'd2, 3'd3, 2'd2, 1'b1, 8'hff),
              32'h11223344, 32'haabbccdd, 32'h55667788, 32'hffff0041);
      add_row(alu_word(K_ALU, 3'b100, 3'd1, 3'd0, 3'd0, 2'd0, 1'b0, 8'h00),
              32'h000000ee, 32'h0, 32'h0, 32'h0);
      add_row(alu_word(K_ALU, 3'b011, 3'd0, 3'd2, 3'd3, 2'd1, 1'b0, 8'h00),
              32'h0, 32'hffff1234, 32'h0000beef, 32'h0);
      add_row(alu_word(K_ALU, 3'b111, 3'd4, 3'd4, 3'd4, 2'd2, 1'b0, 8'h00),
              32'ha1a1a1a1, 32'hb2b2b2b2, 32'hc3c3c3c3, 32'h0);
      add_row(alu_word(K_ALU, 3'b110, 3'd5, 3'd5, 3'd0, 2'd0, 1'b0, 8'h00),
              32'h11111111, 32'h22222222, 32'h0, 32'h0);
      add_row(alu_word(K_ALU, 3'b101, 3'd6, 3'd0, 3'd6, 2'd2, 1'b0, 8'h00),
              32'h66666666, 32'h99999999, 32'h77777777, 32'h0);
      // flag masking
      add_row(alu_word(K_ALU, 3'b000, 3'd0, 3'd0, 3'd0, 2'd2, 1'b1, 8'h40),
              32'h0, 32'h0, 32'h0, 32'h0);
      add_row(alu_word(K_ALU, 3'b000, 3'd0, 3'd0, 3'd0, 2'd2, 1'b0, 8'hff),
              32'h0, 32'h0, 32'h0, 32'hff);
      // branches with CF set and ZF clear
      for (int c = 0; c < 4; c++) add_row(br_word(2'(c)), 32'h5a, 32'ha5, 32'h0, 32'h0);
      add_row(alu_word(K_ALU, 3'b000, 3'd0, 3'd0, 3'd0, 2'd2, 1'b1, 8'hff),
              32'h0, 32'h0, 32'h0, 32'h0);
      add_row(br_word(2'd2), 32'h0, 32'h0, 32'h0, 32'h0);
      add_row(br_word(2'd3), 32'h0, 32'h0, 32'h0, 32'h0);
      add_row(alu_word(K_ALU, 3'b000, 3'd0, 3'd0, 3'd0, 2'd2, 1'b1, 8'h41),
              32'h0, 32'h0, 32'h0, 32'h40);
      add_row(br_word(2'd1), 32'h0, 32'h0, 32'h0, 32'h0);
      add_row(br_word(2'd2), 32'h0, 32'h0, 32'h0, 32'h0);
      // back-to-back stores outnumbering the credits
      for (int s = 0; s < 7; s++) begin
         add_row(alu_word(K_ST, (s == 3) ? 3'b100 : 3'b000, 3'd7, 3'd0, 3'd0, 2'd2,
                          1'b0, 8'h00),
                 32'h70000000 + 32'(s), 32'h0, 32'hd0000000 + 32'(s), 32'h0);
      end
      add_row({K_HLT, 30'd0}, 32'h0, 32'h0, 32'h0, 32'h0);
      // ignored after halt
      add_row(alu_word(K_ALU, 3'b100, 3'd0, 3'd0, 3'd0, 2'd2, 1'b1, 8'hff),
              32'hdeadbeef, 32'h0, 32'h0, 32'hff);
      add_row(br_word(2'd0), 32'h0, 32'h0, 32'h0, 32'h0);
      add_row(alu_word(K_ST, 3'b000, 3'd0, 3'd0, 3'd0, 2'd2, 1'b0, 8'h00),
              32'h0, 32'h0, 32'h12345678, 32'h0);

      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      check_state();

      foreach (rows[i]) run_row(rows[i]);

      // let the dcache return every credit
      while (due.size() > 0) @(negedge clk);
      repeat (2) @(negedge clk);

      if (!saw_stall) begin
         errors++;
         $display("[ERROR] stall never rose while the store credits were used up");
      end
      check_value("store_count", 32'(got_st_addr.size()), 32'(exp_st_addr.size()));
      if (got_st_addr.size() == exp_st_addr.size()) begin
         foreach (exp_st_addr[i]) begin
            check_value("store_addr", got_st_addr[i], exp_st_addr[i]);
            check_value("store_data", got_st_data[i], exp_st_data[i]);
         end
      end

      $display("checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wb_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_core_sva (
   input logic                    clk,
   input logic                    arst_n,
   input logic                    store_valid,
   input logic                    stall,
   input logic                    halted,
   input logic [`WB_CREDIT_W-1:0] credit_cnt
);

   // a store needs a credit in hand
   a_store_needs_credit: assert property (
      @(posedge clk) disable iff (!arst_n) store_valid |-> (credit_cnt != '0)
   ) else $error("store issued with zero credits");

   a_stall_blocks_store: assert property (
      @(posedge clk) disable iff (!arst_n) stall |-> !store_valid
   ) else $error("store_valid high while stalled");

   a_credit_bound: assert property (
      @(posedge clk) disable iff (!arst_n)
         credit_cnt <= `WB_CREDIT_W'(`WB_STORE_CREDITS)
   ) else $error("credit count above initial value");

   // halted core stops all traffic
   a_no_store_halted: assert property (
      @(posedge clk) disable iff (!arst_n) halted |-> !store_valid
   ) else $error("store issued while halted");

endmodule

bind wb_core wb_core_sva i_sva (
   .clk         (clk),
   .arst_n      (arst_n),
   .store_valid (store_valid),
   .stall       (stall),
   .halted      (halted),
   .credit_cnt  (u_ctrl.credit_cnt)
);

`default_nettype wire

// ==== wb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_core (
   input  logic                 clk,
   input  logic                 arst_n,

   input  logic                 in_valid,
   input  logic [`WB_XLEN-1:0]  in_ctrl,
   input  logic [`WB_XLEN-1:0]  in_result_a,
   input  logic [`WB_XLEN-1:0]  in_result_b,
   input  logic [`WB_XLEN-1:0]  in_result_c,
   input  logic [`WB_XLEN-1:0]  in_flags,
   input  logic [`WB_XLEN-1:0]  in_neip,
   input  logic [`WB_XLEN-1:0]  in_target,
   input  logic [`WB_XLEN-1:0]  in_addr,
   output logic                 stall,

   output logic                 store_valid,
   output logic [`WB_XLEN-1:0]  store_addr,
   output logic [`WB_XLEN-1:0]  store_data,
   input  logic                 credit_return,

   input  logic [`WB_GPR_AW-1:0] rd_addr_a,
   input  logic [`WB_GPR_AW-1:0] rd_addr_b,
   output logic [`WB_XLEN-1:0]  rd_data_a,
   output logic [`WB_XLEN-1:0]  rd_data_b,

   output logic [`WB_XLEN-1:0]  eip,
   output logic [`WB_XLEN-1:0]  flags,
   output logic                 halted,
   output logic                 branch_taken
);
   import wb_pkg::*;

   wb_ctrl_u                                ctrl_word;
   logic [`WB_NUM_GPR-1:0][`WB_XLEN-1:0]    gpr_values;

   wb_gpr_if u_gpr_if ();

   assign ctrl_word = in_ctrl;

   wb_ctrl u_ctrl (
      .clk           (clk),
      .arst_n        (arst_n),
      .in_valid      (in_valid),
      .in_ctrl       (ctrl_word),
      .in_result_a   (in_result_a),
      .in_result_b   (in_result_b),
      .in_result_c   (in_result_c),
      .in_flags      (in_flags),
      .in_neip       (in_neip),
      .in_target     (in_target),
      .in_addr       (in_addr),
      .credit_return (credit_return),
      .stall         (stall),
      .store_valid   (store_valid),
      .store_addr    (store_addr),
      .store_data    (store_data),
      .eip           (eip),
      .flags         (flags),
      .halted        (halted),
      .branch_taken  (branch_taken),
      .gpr           (u_gpr_if.ctrl)
   );

   // one slice per architectural register
   for (genvar g = 0; g < `WB_NUM_GPR; g++) begin : g_gpr
      gpr_slice #(
         .IDX (g)
      ) u_slice (
         .clk    (clk),
         .arst_n (arst_n),
         .wr     (u_gpr_if.slice),
         .value  (gpr_values[g])
      );
   end

   gpr_read_mux u_read_mux (
      .values    (gpr_values),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

endmodule

`default_nettype wire

// ==== gpr_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module gpr_read_mux (
   input  logic [`WB_NUM_GPR-1:0][`WB_XLEN-1:0]  values,
   input  logic [`WB_GPR_AW-1:0]                 rd_addr_a,
   input  logic [`WB_GPR_AW-1:0]                 rd_addr_b,
   output logic [`WB_XLEN-1:0]                   rd_data_a,
   output logic [`WB_XLEN-1:0]                   rd_data_b
);

   // two independent ports, no read latency
   always_comb begin
      rd_data_a = '0;
      rd_data_b = '0;
      for (int r = 0; r < `WB_NUM_GPR; r++) begin
         if (rd_addr_a == `WB_GPR_AW'(r)) begin
            rd_data_a = values[r];
         end
         if (rd_addr_b == `WB_GPR_AW'(r)) begin
            rd_data_b = values[r];
         end
      end
   end

endmodule

`default_nettype wire

// ==== gpr_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module gpr_slice #(
   parameter int IDX = 0
) (
   input  logic                 clk,
   input  logic                 arst_n,
   wb_gpr_if.slice              wr,
   output logic [`WB_XLEN-1:0]  value
);
   import wb_pkg::*;

   localparam logic [`WB_GPR_AW-1:0] MY_ADDR = `WB_GPR_AW'(IDX);

   logic                 hit;
   logic [`WB_XLEN-1:0]  sel_data;
   wb_size_e             sel_size;

   // partial writes keep the upper bits
   function automatic logic [`WB_XLEN-1:0] merge_by_size(
      input logic [`WB_XLEN-1:0] old_v,
      input logic [`WB_XLEN-1:0] new_v,
      input wb_size_e            sz
   );
      case (sz)
         SIZE_BYTE: merge_by_size = {old_v[`WB_XLEN-1:8], new_v[7:0]};
         SIZE_WORD: merge_by_size = {old_v[`WB_XLEN-1:16], new_v[15:0]};
         default:   merge_by_size = new_v;
      endcase
   endfunction

   // later ports override earlier ones
   always_comb begin
      hit      = 1'b0;
      sel_data = '0;
      sel_size = SIZE_DWORD;
      for (int p = 0; p < `WB_NUM_WR_PORTS; p++) begin
         if (wr.valid[p] && (wr.addr[p] == MY_ADDR)) begin
            hit      = 1'b1;
            sel_data = wr.data[p];
            sel_size = wr.size[p];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         value <= '0;
      end else if (hit) begin
         value <= merge_by_size(value, sel_data, sel_size);
      end
   end

endmodule

`default_nettype wire

// ==== wb_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

module wb_ctrl (
   input  logic                 clk,
   input  logic                 arst_n,

   input  logic                 in_valid,
   input  wb_pkg::wb_ctrl_u     in_ctrl,
   input  logic [`WB_XLEN-1:0]  in_result_a,
   input  logic [`WB_XLEN-1:0]  in_result_b,
   input  logic [`WB_XLEN-1:0]  in_result_c,
   input  logic [`WB_XLEN-1:0]  in_flags,
   input  logic [`WB_XLEN-1:0]  in_neip,
   input  logic [`WB_XLEN-1:0]  in_target,
   input  logic [`WB_XLEN-1:0]  in_addr,
   input  logic                 credit_return,

   output logic                 stall,
   output logic                 store_valid,
   output logic [`WB_XLEN-1:0]  store_addr,
   output logic [`WB_XLEN-1:0]  store_data,
   output logic [`WB_XLEN-1:0]  eip,
   output logic [`WB_XLEN-1:0]  flags,
   output logic                 halted,
   output logic                 branch_taken,

   wb_gpr_if.ctrl               gpr
);
   import wb_pkg::*;

   wb_kind_e                 kind;
   logic                     is_alu_view;
   logic                     retire;
   logic                     no_credit;
   logic                     cond_ok;
   logic                     taken;
   logic                     ld_flags;
   logic [`WB_XLEN-1:0]      flag_mask_ext;
   logic [`WB_CREDIT_W-1:0]  credit_cnt;

   // kind sits in the same bits of both views
   assign kind        = in_ctrl.alu.kind;
   assign is_alu_view = (kind == KIND_ALU) || (kind == KIND_STORE);

   // store waits for a dcache credit
   assign no_credit = (credit_cnt == '0);
   assign stall     = in_valid && !halted && (kind == KIND_STORE) && no_credit;
   assign retire    = in_valid && !halted && !stall;

   // branch condition against the flags already committed
   always_comb begin
      case (in_ctrl.br.cond)
         COND_ALWAYS: cond_ok = 1'b1;
         COND_NE:     cond_ok = !flags[`WB_FLAG_ZF];
         COND_NBE:    cond_ok = !flags[`WB_FLAG_CF] && !flags[`WB_FLAG_ZF];
         default:     cond_ok = flags[`WB_FLAG_CF];
      endcase
   end

   assign taken        = (kind == KIND_BRANCH) && cond_ok;
   assign branch_taken = in_valid && !halted && taken;

   // register write requests
   assign gpr.valid[0] = retire && is_alu_view && in_ctrl.alu.ld_gpr1;
   assign gpr.valid[1] = retire && is_alu_view && in_ctrl.alu.ld_gpr2;
   assign gpr.valid[2] = retire && is_alu_view && in_ctrl.alu.ld_gpr3;

   assign gpr.addr[0] = in_ctrl.alu.dr1;
   assign gpr.addr[1] = in_ctrl.alu.dr2;
   assign gpr.addr[2] = in_ctrl.alu.dr3;

   assign gpr.data[0] = in_result_a;
   assign gpr.data[1] = in_result_b;
   assign gpr.data[2] = in_result_c;

   assign gpr.size[0] = in_ctrl.alu.size;
   assign gpr.size[1] = in_ctrl.alu.size;
   assign gpr.size[2] = in_ctrl.alu.size;

   // dcache write
   assign store_valid = retire && (kind == KIND_STORE);
   assign store_addr  = in_addr;
   assign store_data  = in_result_c;

   // mask only reaches the low flag byte
   assign flag_mask_ext = {{(`WB_XLEN - `WB_FLAG_MASK_W){1'b0}}, in_ctrl.alu.flag_mask};
   assign ld_flags      = retire && is_alu_view && in_ctrl.alu.ld_flags;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flags <= '0;
      end else if (ld_flags) begin
         flags <= (flags & ~flag_mask_ext) | (in_flags & flag_mask_ext);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         eip <= '0;
      end else if (retire) begin
         eip <= taken ? in_target : in_neip;
      end
   end

   // sticky until reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halted <= 1'b0;
      end else if (retire && (kind == KIND_HALT)) begin
         halted <= 1'b1;
      end
   end

   // a return in the same cycle as a store cancels out
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credit_cnt <= `WB_CREDIT_W'(`WB_STORE_CREDITS);
      end else begin
         case ({store_valid, credit_return})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== wb_gpr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_cfg.svh"

interface wb_gpr_if;
   import wb_pkg::*;

   // index 0 is port 1, index 2 is port 3
   logic     [`WB_NUM_WR_PORTS-1:0]                  valid;
   logic     [`WB_NUM_WR_PORTS-1:0][`WB_GPR_AW-1:0]  addr;
   logic     [`WB_NUM_WR_PORTS-1:0][`WB_XLEN-1:0]    data;
   wb_size_e [`WB_NUM_WR_PORTS-1:0]                  size;

   modport ctrl (
      output valid,
      output addr,
      output data,
      output size
   );

   modport slice (
      input valid,
      input addr,
      input data,
      input size
   );

endinterface

`default_nettype wire

// ==== wb_pkg.sv ====
`default_nettype none

`include "wb_cfg.svh"

package wb_pkg;

   typedef enum logic [1:0] {
      KIND_ALU    = 2'd0,
      KIND_BRANCH = 2'd1,
      KIND_STORE  = 2'd2,
      KIND_HALT   = 2'd3
   } wb_kind_e;

   typedef enum logic [1:0] {
      COND_ALWAYS = 2'd0,
      COND_NE     = 2'd1,
      COND_NBE    = 2'd2,
      COND_C      = 2'd3
   } wb_cond_e;

   // 2'd3 is unused and treated as a full write
   typedef enum logic [1:0] {
      SIZE_BYTE  = 2'd0,
      SIZE_WORD  = 2'd1,
      SIZE_DWORD = 2'd2
   } wb_size_e;

   localparam int ALU_PAD_W = `WB_XLEN - 2 - 3 - 3 * `WB_GPR_AW - 2 - 1 - `WB_FLAG_MASK_W;

   typedef struct packed {
      wb_kind_e                    kind;
      logic                        ld_gpr1;
      logic                        ld_gpr2;
      logic                        ld_gpr3;
      logic [`WB_GPR_AW-1:0]       dr1;
      logic [`WB_GPR_AW-1:0]       dr2;
      logic [`WB_GPR_AW-1:0]       dr3;
      wb_size_e                    size;
      logic                        ld_flags;
      logic [`WB_FLAG_MASK_W-1:0]  flag_mask;
      logic [ALU_PAD_W-1:0]        pad;
   } wb_alu_view_t;

   typedef struct packed {
      wb_kind_e                    kind;
      wb_cond_e                    cond;
      logic [`WB_XLEN-5:0]         pad;
   } wb_br_view_t;

   // same control word, two decodes
   typedef union packed {
      wb_alu_view_t alu;
      wb_br_view_t  br;
   } wb_ctrl_u;

endpackage

`default_nettype wire

// ==== wb_cfg.svh ====
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// datapath and register file geometry
`define WB_XLEN          32
`define WB_NUM_GPR       8
`define WB_GPR_AW        3
`define WB_NUM_WR_PORTS  3

// dcache store credits
`define WB_STORE_CREDITS 4
`define WB_CREDIT_W      3

// flag bit positions, mask covers the low byte
`define WB_FLAG_CF       0
`define WB_FLAG_ZF       6
`define WB_FLAG_MASK_W   8

`endif
